//--- camera_types_pkg.sv
// Assumes a 12-bit sensor bus and lines and frames shorter than 4096 samples
package camera_types_pkg;

    // One raw sensor sample as it appears on the parallel data pins
    typedef logic [11:0] pixel_t;

    // Upper byte of a sample, the only part that goes into the FIFO
    typedef logic [7:0] fifo_byte_t;

    // Line index inside a sensor frame, zero based
    typedef logic [11:0] line_num_t;

    // Pixel position inside a line, zero based
    typedef logic [11:0] pixel_count_t;

    // Index of the interleaved frame, enough for 32 of them
    typedef logic [4:0] ilv_index_t;

    // Whole camera bus as one word so every bit sees the same delay
    typedef struct packed {
        logic   pixclk;
        logic   fv;
        logic   lv;
        pixel_t data;
    } cam_bus_t;

    // Conditioned bus, levels are voted and the pulses last one cycle
    typedef struct packed {
        logic   fv;
        logic   lv;
        pixel_t data;
        logic   frame_start;
        logic   line_start;
        logic   line_end;
        logic   sample_pulse;
        // Frame valid low, line valid low and all data bits zero
        logic   out_of_frame;
    } cam_events_t;

    // Position of the sensor inside its frame as seen by the tracker
    typedef struct packed {
        logic      line_active;
        line_num_t line_in_frame;
        line_num_t prev_line;
        logic      line_counted;
        logic      frame_ended;
    } line_status_t;

endpackage

//--- capture_ctrl_pkg.sv
// State encodings fit in 3 bits, the one unused code is treated as BOOT
package capture_ctrl_pkg;

    // Capture FSM states, bring-up first and the image loop last
    typedef enum logic [2:0] {
        BOOT             = 3'd0,
        CAM_UNRESET      = 3'd1,
        WAIT_FRAME_START = 3'd2,
        WAIT_FRAME_END   = 3'd3,
        IDLE             = 3'd4,
        WAIT_BLANKING    = 3'd5,
        STREAMING        = 3'd6
    } capture_state_t;

    // Status sent back from the FSM to the tracking logic
    typedef struct packed {
        // High only while lines are being written to the FIFO
        logic streaming;
        // High once the camera has been brought up on a frame boundary
        logic tracking_enabled;
    } capture_status_t;

endpackage

//--- bus_conditioner.sv
// Needs 8 or more system clocks per pixel clock and a sample_delay of at least 1
`timescale 1ns/1ps

module bus_conditioner #(
    parameter int sync_stages  = 10,
    parameter int sample_delay = 2
) (
    input  logic                          clk,
    input  logic                          reset,
    input  camera_types_pkg::cam_bus_t    cam_in,
    output camera_types_pkg::cam_events_t events
);
    import camera_types_pkg::*;

    // ******************************************************************
    // Synchronizer chain and three word buffer
    // ******************************************************************

    // The whole bus moves together so relative phase is preserved
    cam_bus_t sync_q [sync_stages];
    cam_bus_t buf_q  [3];
    cam_bus_t voted;
    // Registered vote and the output stage where edges are found
    cam_bus_t filt_q;
    cam_bus_t out_q;
    logic     pclk_fall_q;
    logic     frame_start_q;
    logic     frame_end_q;
    logic     line_start_q;
    logic     line_end_q;
    logic [sample_delay-1:0] delay_q;

    // Bitwise two out of three vote removes any single cycle blip
    assign voted = (buf_q[2] & buf_q[1]) | (buf_q[2] & buf_q[0]) | (buf_q[1] & buf_q[0]);

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q        <= '{default: '0};
            buf_q         <= '{default: '0};
            filt_q        <= '0;
            out_q         <= '0;
            pclk_fall_q   <= 1'b0;
            frame_start_q <= 1'b0;
            frame_end_q   <= 1'b0;
            line_start_q  <= 1'b0;
            line_end_q    <= 1'b0;
            delay_q       <= '0;
        end else begin
            sync_q[0] <= cam_in;
            for (int i = 1; i < sync_stages; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            buf_q[0] <= sync_q[sync_stages-1];
            buf_q[1] <= buf_q[0];
            buf_q[2] <= buf_q[1];
            filt_q   <= voted;
            out_q    <= filt_q;
            // Edges land in the same cycle as the level change on out_q
            pclk_fall_q   <= out_q.pixclk & ~filt_q.pixclk;
            frame_start_q <= filt_q.fv & ~out_q.fv;
            frame_end_q   <= out_q.fv & ~filt_q.fv;
            line_start_q  <= filt_q.lv & ~out_q.lv;
            line_end_q    <= out_q.lv & ~filt_q.lv;
            // Data settles a few cycles after the pixel clock falls
            delay_q[0] <= pclk_fall_q;
            for (int i = 1; i < sample_delay; i++) begin
                delay_q[i] <= delay_q[i-1];
            end
        end
    end

    // ******************************************************************
    // Event word
    // ******************************************************************

    always_comb begin
        events.fv           = out_q.fv;
        events.lv           = out_q.lv;
        events.data         = out_q.data;
        events.frame_start  = frame_start_q;
        events.line_start   = line_start_q;
        events.line_end     = line_end_q;
        events.sample_pulse = delay_q[sample_delay-1];
        events.out_of_frame = !out_q.fv && !out_q.lv && (out_q.data == '0);
    end

    // The vote keeps frame valid steady and no end follows right after a start
    assert property (@(posedge clk) disable iff (reset)
        frame_start_q |=> !frame_end_q);

endmodule

//--- line_tracker.sv
// Counts hold at zero while tracking is disabled and line_size must be below 4096
`timescale 1ns/1ps

module line_tracker #(
    parameter int line_size = 2592
) (
    input  logic                              clk,
    input  logic                              reset,
    input  camera_types_pkg::cam_events_t     events,
    input  capture_ctrl_pkg::capture_status_t status,
    output camera_types_pkg::line_status_t    line
);
    import camera_types_pkg::*;

    logic         line_active;
    pixel_count_t pix_count;
    line_num_t    line_in_frame;
    line_num_t    prev_line;
    // Set inside a line and cleared when that line is counted
    logic         rearm;
    logic         line_counted;
    logic         frame_ended;
    logic         line_over;

    // Line end is only trusted when every input agrees it is blanking
    assign line_over = !events.lv && !line_active && (events.data == '0) && rearm;

    // ******************************************************************
    // Line state and pixel counter
    // ******************************************************************

    always_ff @(posedge clk) begin
        if (reset || !status.tracking_enabled) begin
            line_active <= 1'b0;
            pix_count   <= '0;
        end else if (line_active) begin
            // Greater or equal so an upset count still leaves the line
            if (pix_count >= line_size) begin
                line_active <= 1'b0;
                pix_count   <= '0;
            end else if (events.sample_pulse) begin
                pix_count <= pix_count + 1'b1;
            end
        end else if (events.lv && !rearm) begin
            // A new line may start only after the last one was counted
            line_active <= 1'b1;
        end
    end

    // ******************************************************************
    // Line counter advanced in the blanking that follows each line
    // ******************************************************************

    always_ff @(posedge clk) begin
        if (reset || !status.tracking_enabled) begin
            line_in_frame <= '0;
            prev_line     <= '0;
            rearm         <= 1'b0;
            line_counted  <= 1'b0;
            frame_ended   <= 1'b0;
        end else begin
            line_counted <= line_over;
            frame_ended  <= events.out_of_frame && !line_active;
            if (line_over) begin
                rearm         <= 1'b0;
                prev_line     <= line_in_frame;
                line_in_frame <= line_in_frame + 1'b1;
            end
            if (line_active) begin
                rearm <= 1'b1;
            end
            // Frame boundary wins over a count in the same cycle
            if (events.out_of_frame && !line_active) begin
                line_in_frame <= '0;
            end
        end
    end

    always_comb begin
        line.line_active   = line_active;
        line.line_in_frame = line_in_frame;
        line.prev_line     = prev_line;
        line.line_counted  = line_counted;
        line.frame_ended   = frame_ended;
    end

    // Line valid must not drop before the last sample of the line is counted
    assert property (@(posedge clk) disable iff (reset)
        line_active && !events.lv |-> pix_count >= line_size);

endmodule

//--- interleave_scheduler.sv
// n_interleave must divide lines_in_frame and be 32 or less
`timescale 1ns/1ps

module interleave_scheduler #(
    parameter int lines_in_frame = 1944,
    parameter int n_interleave   = 8
) (
    input  logic                              clk,
    input  logic                              reset,
    input  camera_types_pkg::cam_events_t     events,
    input  camera_types_pkg::line_status_t    line,
    input  capture_ctrl_pkg::capture_status_t status,
    output camera_types_pkg::line_num_t       target_line,
    output logic                              all_frames_done
);
    import camera_types_pkg::*;

    // Two lines read then 2n-2 skipped, so the mean step is still n
    localparam int jump_size       = 2 * n_interleave - 1;
    localparam int lines_per_frame = lines_in_frame / n_interleave;

    // Three copies of the target, an upset in one is outvoted
    line_num_t  target_copy [3];
    line_num_t  line_in_ilv;
    ilv_index_t frame_idx;
    line_num_t  step_target;
    logic       last_line;
    logic       advance;

    assign target_line = (target_copy[2] & target_copy[1])
                       | (target_copy[2] & target_copy[0])
                       | (target_copy[1] & target_copy[0]);

    // Move on only after the target line was counted, in line blanking
    assign advance   = line.line_counted && !events.lv && (line.prev_line == target_line);
    assign last_line = (line_in_ilv >= lines_per_frame - 1);

    // ******************************************************************
    // Next target inside the current interleaved frame
    // ******************************************************************

    always_comb begin
        if (!target_line[0]) begin
            // Even line, take its odd partner to keep the Bayer pair
            step_target = target_line + 1'b1;
        end else if (target_line < lines_in_frame - jump_size) begin
            step_target = target_line + line_num_t'(jump_size);
        end else begin
            // Past the end, fill in a pair half that an earlier frame lost
            step_target = target_line + line_num_t'(n_interleave);
        end
    end

    always_ff @(posedge clk) begin
        if (reset || !status.streaming) begin
            target_copy     <= '{default: '0};
            line_in_ilv     <= '0;
            frame_idx       <= '0;
            all_frames_done <= 1'b0;
        end else if (advance) begin
            if (last_line) begin
                line_in_ilv <= '0;
                if (frame_idx >= n_interleave - 1) begin
                    all_frames_done <= 1'b1;
                end else begin
                    frame_idx <= frame_idx + 1'b1;
                    // Each new frame starts two lines further down
                    for (int i = 0; i < 3; i++) begin
                        target_copy[i] <= line_num_t'(2 * (frame_idx + 1));
                    end
                end
            end else begin
                line_in_ilv <= line_in_ilv + 1'b1;
                for (int i = 0; i < 3; i++) begin
                    target_copy[i] <= step_target;
                end
            end
        end else if (target_line >= lines_in_frame) begin
            // Target can never match again, so the image ends short
            all_frames_done <= 1'b1;
        end
    end

endmodule

//--- capture_fsm.sv
// boot_cycles sets both the camera reset hold and the settle time after release
`timescale 1ns/1ps

module capture_fsm #(
    parameter int boot_cycles = 50_000_000
) (
    input  logic                              clk,
    input  logic                              reset,
    input  camera_types_pkg::cam_events_t     events,
    input  camera_types_pkg::line_status_t    line,
    input  camera_types_pkg::line_num_t       target_line,
    input  logic                              all_frames_done,
    input  logic                              request_image,
    output logic                              camera_reset_bar,
    output capture_ctrl_pkg::capture_status_t status,
    output logic                              image_started,
    output logic                              image_finished,
    output logic                              keep_pixel
);
    import capture_ctrl_pkg::*;

    localparam int timer_w = $clog2(boot_cycles + 1);

    capture_state_t     state;
    capture_state_t     state_next;
    logic [timer_w-1:0] timer;
    logic               timer_done;

    // Timer restarts on every state change and saturates at the end
    assign timer_done = (timer >= boot_cycles - 1);

    // ******************************************************************
    // Next state
    // ******************************************************************

    always_comb begin
        state_next = state;
        case (state)
            BOOT: begin
                if (timer_done) begin
                    state_next = CAM_UNRESET;
                end
            end
            CAM_UNRESET: begin
                if (timer_done) begin
                    state_next = WAIT_FRAME_START;
                end
            end
            // One whole frame passes so tracking starts on a boundary
            WAIT_FRAME_START: begin
                if (events.fv) begin
                    state_next = WAIT_FRAME_END;
                end
            end
            WAIT_FRAME_END: begin
                if (events.out_of_frame) begin
                    state_next = IDLE;
                end
            end
            IDLE: begin
                if (request_image) begin
                    state_next = WAIT_BLANKING;
                end
            end
            WAIT_BLANKING: begin
                if (events.out_of_frame) begin
                    state_next = STREAMING;
                end
            end
            STREAMING: begin
                if (all_frames_done) begin
                    state_next = IDLE;
                end
            end
            // Unused code falls back to a full restart
            default: begin
                state_next = BOOT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state            <= BOOT;
            timer            <= '0;
            camera_reset_bar <= 1'b0;
        end else begin
            state <= state_next;
            if (state_next != state) begin
                timer <= '0;
            end else if (!timer_done) begin
                timer <= timer + 1'b1;
            end
            // Registered so the camera reset pin never glitches
            camera_reset_bar <= (state_next != BOOT);
        end
    end

    // ******************************************************************
    // Outputs
    // ******************************************************************

    always_comb begin
        status.streaming        = (state == STREAMING);
        status.tracking_enabled = (state == IDLE) || (state == WAIT_BLANKING) || status.streaming;
        image_started           = status.streaming;
        image_finished          = !status.streaming;
        keep_pixel = line.line_active && (line.line_in_frame == target_line) && status.streaming;
    end

    // Keep only inside a running image that the scheduler has not closed
    assert property (@(posedge clk) disable iff (reset)
        keep_pixel |-> image_started && !all_frames_done);

endmodule

//--- camera_capture_top.sv
// Camera bus is asynchronous to clk, and the FIFO is assumed never to fill
`timescale 1ns/1ps

module camera_capture_top #(
    parameter int sync_stages    = 10,
    parameter int sample_delay   = 2,
    parameter int line_size      = 2592,
    parameter int lines_in_frame = 1944,
    parameter int n_interleave   = 8,
    parameter int boot_cycles    = 50_000_000
) (
    input  logic                         clk,
    input  logic                         reset,
    input  camera_types_pkg::cam_bus_t   cam_in,
    input  logic                         request_image,
    output logic                         camera_reset_bar,
    output logic                         image_started,
    output logic                         image_finished,
    output camera_types_pkg::fifo_byte_t data_for_fifo,
    output logic                         sample_pixel_pulse,
    output logic                         keep_pixel
);
    import camera_types_pkg::*;
    import capture_ctrl_pkg::*;

    cam_events_t     events;
    line_status_t    line_status;
    line_num_t       target_line;
    logic            all_frames_done;
    capture_status_t status;

    // FIFO takes the upper byte on every strobe, keep_pixel is its enable
    assign data_for_fifo      = events.data[11:4];
    assign sample_pixel_pulse = events.sample_pulse;

    bus_conditioner #(
        .sync_stages (sync_stages),
        .sample_delay(sample_delay)
    ) u_bus_conditioner (
        .clk   (clk),
        .reset (reset),
        .cam_in(cam_in),
        .events(events)
    );

    line_tracker #(
        .line_size(line_size)
    ) u_line_tracker (
        .clk   (clk),
        .reset (reset),
        .events(events),
        .status(status),
        .line  (line_status)
    );

    interleave_scheduler #(
        .lines_in_frame(lines_in_frame),
        .n_interleave  (n_interleave)
    ) u_interleave_scheduler (
        .clk            (clk),
        .reset          (reset),
        .events         (events),
        .line           (line_status),
        .status         (status),
        .target_line    (target_line),
        .all_frames_done(all_frames_done)
    );

    capture_fsm #(
        .boot_cycles(boot_cycles)
    ) u_capture_fsm (
        .clk             (clk),
        .reset           (reset),
        .events          (events),
        .line            (line_status),
        .target_line     (target_line),
        .all_frames_done (all_frames_done),
        .request_image   (request_image),
        .camera_reset_bar(camera_reset_bar),
        .status          (status),
        .image_started   (image_started),
        .image_finished  (image_finished),
        .keep_pixel      (keep_pixel)
    );

endmodule

//--- camera_capture_checker.sv
// Expects one byte value per sensor line, at most 8 kept lines per test, samples on negedge
`timescale 1ns/1ps

module camera_capture_checker #(
    parameter int         boot_cycles = 20,
    parameter int         line_size   = 6,
    parameter logic [7:0] first_byte  = 8'h10
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         camera_reset_bar,
    input  logic                         image_started,
    input  logic                         image_finished,
    input  camera_types_pkg::fifo_byte_t data_for_fifo,
    input  logic                         sample_pixel_pulse,
    input  logic                         keep_pixel,
    input  logic                         test_start,
    input  logic                         test_end,
    input  int                           test_num,
    input  logic                         exp_request,
    input  int                           exp_count,
    input  logic [31:0]                  exp_lines,
    output int                           error_count,
    output int                           tests_done
);
    import camera_types_pkg::*;

    int         boot_low;
    logic       bar_seen;
    logic       test_active;
    logic       line_open;
    fifo_byte_t cur_byte;
    fifo_byte_t exp_byte;
    int         cur_count;
    int         kept_idx;
    int         test_errors;
    logic       started_seen;
    logic       finished_dropped;

    task automatic count_failure();
        test_errors++;
        error_count++;
    endtask

    // Every kept line must deliver exactly one full line of strobes
    task automatic close_line();
        if (cur_count != line_size) begin
            $display("error sample_pixel_pulse count for byte 8'h%h: expected 'h%h, got 'h%h",
                     cur_byte, line_size, cur_count);
            count_failure();
        end
        line_open = 1'b0;
    endtask

    // ******************************************************************
    // One kept byte, a change of byte value starts the next line
    // ******************************************************************

    task automatic take_byte();
        if (!test_active) begin
            $display("a pixel was kept while no test was running");
            count_failure();
        end else begin
            if (!line_open || data_for_fifo != cur_byte) begin
                if (line_open) begin
                    close_line();
                end
                line_open = 1'b1;
                cur_byte  = data_for_fifo;
                cur_count = 0;
                if (kept_idx >= exp_count) begin
                    $display("test %0d: line with byte 8'h%h kept after the last expected line",
                             test_num, data_for_fifo);
                    count_failure();
                end else begin
                    // The table lists line numbers, a line's byte is the base plus its number
                    exp_byte = first_byte + fifo_byte_t'(exp_lines[4*kept_idx +: 4]);
                    if (data_for_fifo != exp_byte) begin
                        $display("error data_for_fifo: expected 8'h%h, got 8'h%h",
                                 exp_byte, data_for_fifo);
                        count_failure();
                    end
                end
                kept_idx++;
            end
            cur_count++;
        end
    endtask

    task automatic finish_test();
        if (line_open) begin
            close_line();
        end
        if (kept_idx < exp_count) begin
            $display("test %0d: only %0d of %0d lines were kept", test_num, kept_idx, exp_count);
            count_failure();
        end
        if (exp_request && !started_seen) begin
            $display("test %0d: image_started never rose after the request", test_num);
            count_failure();
        end
        if (!image_finished) begin
            $display("error image_finished: expected 1'h1, got 1'h%h", image_finished);
            count_failure();
        end
        if (finished_dropped) begin
            $display("test %0d: image_finished fell although no image was requested", test_num);
            count_failure();
        end
        $display("test %0d %s: %0d lines kept, %0d errors", test_num,
                 (test_errors == 0) ? "ok" : "FAILED", kept_idx, test_errors);
        tests_done++;
        test_active = 1'b0;
    endtask

    // ******************************************************************
    // Sampling at the falling edge, half a cycle away from any change
    // ******************************************************************

    always @(negedge clk) begin
        if (reset) begin
            boot_low    = 0;
            bar_seen    = 1'b0;
            test_active = 1'b0;
            line_open   = 1'b0;
            error_count = 0;
            tests_done  = 0;
        end else begin
            // Camera must stay in reset for the whole boot interval
            if (!bar_seen) begin
                if (camera_reset_bar) begin
                    bar_seen = 1'b1;
                    if (boot_low < boot_cycles) begin
                        $display("camera_reset_bar released after %0d cycles, %0d needed",
                                 boot_low, boot_cycles);
                        count_failure();
                    end
                end else begin
                    boot_low++;
                end
            end
            if (test_start) begin
                test_active      = 1'b1;
                line_open        = 1'b0;
                kept_idx         = 0;
                test_errors      = 0;
                started_seen     = 1'b0;
                finished_dropped = 1'b0;
            end
            if (sample_pixel_pulse && keep_pixel) begin
                take_byte();
            end
            if (keep_pixel && !image_started) begin
                $display("keep_pixel is high outside a running image");
                count_failure();
            end
            if (test_active) begin
                if (image_started) begin
                    started_seen = 1'b1;
                end
                if (!exp_request && !image_finished) begin
                    finished_dropped = 1'b1;
                end
            end
            if (test_end) begin
                finish_test();
            end
        end
    end

endmodule

//--- tb_camera_capture.sv
// Sensor model with 8 clocks per pixel clock, line bytes run from 0x10 to 0x17
`timescale 1ns/1ps

module tb_camera_capture;
    import camera_types_pkg::*;

    localparam int sync_stages    = 3;
    localparam int sample_delay   = 2;
    localparam int line_size      = 6;
    localparam int lines_in_frame = 8;
    localparam int n_interleave   = 2;
    localparam int boot_cycles    = 20;
    // Sensor timing, counted in pixel clocks except pclk_div
    localparam int pclk_div       = 8;
    localparam int line_blank     = 20;
    localparam int frame_blank    = 60;
    localparam int n_tests        = 4;
    localparam int frame_cycles   =
        pclk_div * (lines_in_frame * (line_size + line_blank) + frame_blank);

    // One row of the stimulus table
    typedef struct packed {
        logic [3:0]  frames_before;
        logic        do_request;
        logic        glitch;
        logic [3:0]  frames_after;
        logic [3:0]  kept_count;
        // Nibble i holds the line number of the i-th kept line
        logic [31:0] kept_lines;
    } test_row_t;

    logic       clk;
    logic       reset;
    cam_bus_t   cam_in;
    logic       request_image;
    logic       camera_reset_bar;
    logic       image_started;
    logic       image_finished;
    fifo_byte_t data_for_fifo;
    logic       sample_pixel_pulse;
    logic       keep_pixel;
    logic       test_start;
    logic       test_end;
    int         test_num;
    test_row_t  row;
    test_row_t  table_rows [n_tests];
    int         error_count;
    int         tests_done;

    camera_capture_top #(
        .sync_stages   (sync_stages),
        .sample_delay  (sample_delay),
        .line_size     (line_size),
        .lines_in_frame(lines_in_frame),
        .n_interleave  (n_interleave),
        .boot_cycles   (boot_cycles)
    ) dut (
        .clk               (clk),
        .reset             (reset),
        .cam_in            (cam_in),
        .request_image     (request_image),
        .camera_reset_bar  (camera_reset_bar),
        .image_started     (image_started),
        .image_finished    (image_finished),
        .data_for_fifo     (data_for_fifo),
        .sample_pixel_pulse(sample_pixel_pulse),
        .keep_pixel        (keep_pixel)
    );

    camera_capture_checker #(
        .boot_cycles(boot_cycles),
        .line_size  (line_size),
        .first_byte (8'h10)
    ) u_checker (
        .clk               (clk),
        .reset             (reset),
        .camera_reset_bar  (camera_reset_bar),
        .image_started     (image_started),
        .image_finished    (image_finished),
        .data_for_fifo     (data_for_fifo),
        .sample_pixel_pulse(sample_pixel_pulse),
        .keep_pixel        (keep_pixel),
        .test_start        (test_start),
        .test_end          (test_end),
        .test_num          (test_num),
        .exp_request       (row.do_request),
        .exp_count         (int'(row.kept_count)),
        .exp_lines         (row.kept_lines),
        .error_count       (error_count),
        .tests_done        (tests_done)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ******************************************************************
    // Camera bus model
    // ******************************************************************

    // One pixel clock, high for the first half, with an optional one clock lv blip
    task automatic drive_pixel(input logic fv, input logic lv, input pixel_t data,
                               input logic glitch);
        for (int i = 0; i < pclk_div; i++) begin
            @(posedge clk);
            #1;
            cam_in.pixclk = (i < pclk_div / 2);
            cam_in.fv     = fv;
            cam_in.lv     = lv | (glitch && i == 5);
            cam_in.data   = data;
        end
    endtask

    // Lines with their blanking, then the frame blanking with fv low
    task automatic send_frame(input logic glitch);
        pixel_t value;
        for (int ln = 0; ln < lines_in_frame; ln++) begin
            for (int px = 0; px < line_size; px++) begin
                value = pixel_t'(12'h100 + 16 * ln + px);
                drive_pixel(1'b1, 1'b1, value, 1'b0);
            end
            for (int b = 0; b < line_blank; b++) begin
                drive_pixel(1'b1, 1'b0, '0, glitch && (b == line_blank / 2));
            end
        end
        for (int b = 0; b < frame_blank; b++) begin
            drive_pixel(1'b0, 1'b0, '0, 1'b0);
        end
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #1 test_start = 1'b1;
        @(posedge clk);
        #1 test_start = 1'b0;
    endtask

    task automatic pulse_end();
        @(posedge clk);
        #1 test_end = 1'b1;
        @(posedge clk);
        #1 test_end = 1'b0;
    endtask

    // ******************************************************************
    // Stimulus table applied in a loop
    // ******************************************************************

    initial begin
        int w;
        cam_in        = '0;
        request_image = 1'b0;
        reset         = 1'b1;
        test_start    = 1'b0;
        test_end      = 1'b0;
        test_num      = 0;
        row           = '0;
        // Bring-up frame and one idle frame, nothing kept
        table_rows[0] = '{4'd2, 1'b0, 1'b0, 4'd0, 4'd0, 32'h0000_0000};
        // Full image, then one more frame that must stay unkept
        table_rows[1] = '{4'd0, 1'b1, 1'b0, 4'd3, 4'd8, 32'h7632_5410};
        // Same image with an lv blip in every line blanking
        table_rows[2] = '{4'd0, 1'b1, 1'b1, 4'd2, 4'd8, 32'h7632_5410};
        table_rows[3] = '{4'd1, 1'b1, 1'b0, 4'd2, 4'd8, 32'h7632_5410};
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        for (int t = 0; t < n_tests; t++) begin
            row      = table_rows[t];
            test_num = t;
            pulse_start();
            // A camera held in reset sends nothing
            wait (camera_reset_bar);
            repeat (row.frames_before) send_frame(row.glitch);
            if (row.do_request) begin
                request_image = 1'b1;
                w = 0;
                while (!image_started && w < frame_blank) begin
                    drive_pixel(1'b0, 1'b0, '0, 1'b0);
                    w++;
                end
                request_image = 1'b0;
            end
            repeat (row.frames_after) send_frame(row.glitch);
            pulse_end();
        end
        repeat (4) @(posedge clk);
        $display("%0d tests run, %0d errors", tests_done, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Twice the table's frame count, plus one frame for boot and request waits
    initial begin
        int total_frames;
        int limit;
        @(negedge reset);
        total_frames = 1;
        for (int t = 0; t < n_tests; t++) begin
            total_frames += table_rows[t].frames_before + table_rows[t].frames_after;
        end
        limit = total_frames * frame_cycles * 2;
        repeat (limit) @(posedge clk);
        $display("watchdog: the run did not finish within %0d cycles", limit);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- camera_capture.f
camera_types_pkg.sv
capture_ctrl_pkg.sv
bus_conditioner.sv
line_tracker.sv
interleave_scheduler.sv
capture_fsm.sv
camera_capture_top.sv
camera_capture_checker.sv
tb_camera_capture.sv
